/* core_region.f */
design/core_region_pkg.sv
design/lsu_demux.sv
design/wb_master_bridge.sv
design/wb_slave_bridge.sv
design/ram_arbiter.sv
design/data_ram.sv
design/core_region.sv
tests/core_region_tb.sv

/* tests/core_region_tb.sv */
`timescale 1ns/10ps

module core_region_tb;

  localparam logic [31:0] SEED       = 32'h04b1_efa5;
  localparam int          NUM_WORDS  = 16;
  // operations issued over all phases
  localparam int          NUM_OPS    = 228;
  localparam int          MAX_CYCLES = 40 * NUM_OPS + 10;

  logic                       clk;
  logic                       rst_n;
  logic                       lsu_req_i;
  core_region_pkg::bus_addr_t lsu_addr_i;
  logic                       lsu_we_i;
  core_region_pkg::byte_en_t  lsu_be_i;
  core_region_pkg::word_t     lsu_wdata_i;
  logic                       lsu_gnt_o;
  logic                       lsu_rvalid_o;
  core_region_pkg::word_t     lsu_rdata_o;
  logic                       ext_cyc_o;
  logic                       ext_stb_o;
  logic                       ext_we_o;
  core_region_pkg::bus_addr_t ext_adr_o;
  core_region_pkg::byte_en_t  ext_sel_o;
  core_region_pkg::word_t     ext_dat_o;
  core_region_pkg::word_t     ext_dat_i;
  logic                       ext_ack_i;
  logic                       mem_cyc_i;
  logic                       mem_stb_i;
  logic                       mem_we_i;
  core_region_pkg::ram_addr_t mem_adr_i;
  core_region_pkg::byte_en_t  mem_sel_i;
  core_region_pkg::word_t     mem_dat_i;
  core_region_pkg::word_t     mem_dat_o;
  logic                       mem_ack_o;

  int          errors;
  int          checks;
  int          cycle_cnt;
  logic [31:0] lsu_rng;
  logic [31:0] mem_rng;
  logic [31:0] ws_rng;
  logic        local_gnt_prev;
  logic        ext_ack_prev;

  // shadow copies of both memories and the slave model's own array
  core_region_pkg::word_t     ram_shadow [core_region_pkg::RAM_DEPTH];
  core_region_pkg::word_t     ext_shadow [core_region_pkg::RAM_DEPTH];
  core_region_pkg::word_t     ext_mem    [core_region_pkg::RAM_DEPTH];

  core_region_pkg::word_t     lsu_exp_q[$];
  logic                       lsu_chk_q[$];
  core_region_pkg::word_t     mem_exp_q[$];
  logic                       mem_chk_q[$];
  core_region_pkg::bus_addr_t wb_adr_q[$];
  logic                       wb_we_q[$];
  core_region_pkg::byte_en_t  wb_sel_q[$];
  core_region_pkg::word_t     wb_dat_q[$];

  core_region core_region_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic is_local_addr(input core_region_pkg::bus_addr_t addr);
    return addr[31:20] == core_region_pkg::LOCAL_REGION;
  endfunction

  function automatic core_region_pkg::bus_addr_t make_addr(
    input logic                       to_ext,
    input core_region_pkg::ram_addr_t idx,
    input logic [31:0]                r
  );
    logic [11:0] region;
    region = to_ext ? {1'b1, r[30:20]} : core_region_pkg::LOCAL_REGION;
    return {region, r[19:12], idx, 2'b00};
  endfunction

  // returns the word a read sees and merges a write into the shadow
  function automatic core_region_pkg::word_t model_access(
    input logic                       is_ext,
    input core_region_pkg::ram_addr_t idx,
    input logic                       we,
    input core_region_pkg::byte_en_t  be,
    input core_region_pkg::word_t     wdata
  );
    core_region_pkg::word_t old_word;
    core_region_pkg::word_t merged;
    old_word = is_ext ? ext_shadow[idx] : ram_shadow[idx];
    merged   = old_word;
    for (int b = 0; b < core_region_pkg::BE_WIDTH; b++)
    begin
      if (be[b])
        merged[8*b +: 8] = wdata[8*b +: 8];
    end
    if (we && is_ext)
      ext_shadow[idx] = merged;
    else if (we)
      ram_shadow[idx] = merged;
    return old_word;
  endfunction

  task automatic log_failure(input string msg);
    errors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic check_word(
    input string                  what,
    input core_region_pkg::word_t got,
    input core_region_pkg::word_t exp
  );
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(
    input string                      what,
    input core_region_pkg::bus_addr_t got,
    input core_region_pkg::bus_addr_t exp
  );
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(
    input string                     what,
    input core_region_pkg::byte_en_t got,
    input core_region_pkg::byte_en_t exp
  );
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // called 1 ns after a rising edge and returns 1 ns after the granting edge
  task automatic lsu_op(
    input core_region_pkg::bus_addr_t addr,
    input logic                       we,
    input core_region_pkg::byte_en_t  be,
    input core_region_pkg::word_t     wdata
  );
    logic is_ext;
    is_ext      = !is_local_addr(addr);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    @(negedge clk);
    while (!lsu_gnt_o)
      @(negedge clk);
    lsu_exp_q.push_back(model_access(is_ext, addr[11:2], we, be, wdata));
    lsu_chk_q.push_back(!we);
    if (is_ext)
    begin
      wb_adr_q.push_back(addr);
      wb_we_q.push_back(we);
      wb_sel_q.push_back(be);
      wb_dat_q.push_back(wdata);
    end
    @(posedge clk);
    #1;
    lsu_req_i = 1'b0;
  endtask

  task automatic lsu_read(input core_region_pkg::ram_addr_t idx);
    lsu_rng = xorshift(lsu_rng);
    lsu_op(make_addr(1'b0, idx, lsu_rng), 1'b0, 4'hf, '0);
  endtask

  // target 0 is local, 1 external and 2 either
  task automatic random_lsu_op(input logic [1:0] target, input logic only_writes);
    logic [31:0] r;
    logic        to_ext;
    lsu_rng = xorshift(lsu_rng);
    r       = lsu_rng;
    lsu_rng = xorshift(lsu_rng);
    to_ext  = target[1] ? r[0] : target[0];
    lsu_op(make_addr(to_ext, {6'd0, r[11:8]}, r), only_writes | r[1], r[7:4], lsu_rng);
  endtask

  // slave port access with ack due one cycle after the request
  task automatic mem_op(
    input core_region_pkg::ram_addr_t idx,
    input logic                       we,
    input core_region_pkg::byte_en_t  be,
    input core_region_pkg::word_t     wdata
  );
    mem_cyc_i = 1'b1;
    mem_stb_i = 1'b1;
    mem_we_i  = we;
    mem_adr_i = idx;
    mem_sel_i = be;
    mem_dat_i = wdata;
    @(negedge clk);
    mem_exp_q.push_back(model_access(1'b0, idx, we, be, wdata));
    mem_chk_q.push_back(!we);
    @(negedge clk);
    if (mem_ack_o !== 1'b1)
      log_failure("mem_ack_o did not follow the slave-port request by one cycle");
    @(posedge clk);
    #1;
    mem_cyc_i = 1'b0;
    mem_stb_i = 1'b0;
  endtask

  task automatic random_mem_op();
    logic [31:0] r;
    mem_rng = xorshift(mem_rng);
    r       = mem_rng;
    mem_rng = xorshift(mem_rng);
    mem_op({6'd0, r[11:8]}, r[1], r[7:4], mem_rng);
  endtask

  // external wishbone slave with 0 to 3 wait states
  initial
  begin : ext_slave
    int                         wait_cnt;
    logic                       exp_we;
    core_region_pkg::ram_addr_t idx;
    ws_rng = xorshift(xorshift(SEED));
    forever
    begin
      @(posedge clk);
      #1;
      if (ext_cyc_o && ext_stb_o)
      begin
        if (wb_adr_q.size() == 0)
        begin
          log_failure("Wishbone cycle started with no granted external request");
        end
        else
        begin
          exp_we = wb_we_q.pop_front();
          check_addr("ext_adr_o", ext_adr_o, wb_adr_q.pop_front());
          check_sel("ext_sel_o", ext_sel_o, wb_sel_q.pop_front());
          check_word("ext_dat_o", ext_dat_o, wb_dat_q.pop_front());
          checks++;
          if (ext_we_o !== exp_we)
          begin
            errors++;
            $display("[ERROR] %0t ext_we_o: got %b, expected %b", $time, ext_we_o, exp_we);
          end
        end
        idx      = ext_adr_o[11:2];
        ws_rng   = xorshift(ws_rng);
        wait_cnt = ws_rng[1:0];
        repeat (wait_cnt)
        begin
          @(posedge clk);
          #1;
        end
        ext_dat_i = ext_mem[idx];
        for (int b = 0; b < core_region_pkg::BE_WIDTH; b++)
        begin
          if (ext_we_o && ext_sel_o[b])
            ext_mem[idx][8*b +: 8] = ext_dat_o[8*b +: 8];
        end
        ext_ack_i = 1'b1;
        @(posedge clk);
        #1;
        ext_ack_i = 1'b0;
      end
    end
  end

  // responses checked mid-cycle against the expected queues
  always @(negedge clk)
  begin
    core_region_pkg::word_t exp_word;
    if (rst_n)
    begin
      if (local_gnt_prev && !lsu_rvalid_o)
        log_failure("no lsu_rvalid_o one cycle after a local grant");
      if (ext_ack_prev && !lsu_rvalid_o)
        log_failure("no lsu_rvalid_o one cycle after ext_ack_i");
      if (lsu_rvalid_o && lsu_exp_q.size() == 0)
      begin
        log_failure("lsu_rvalid_o with no request outstanding");
      end
      else if (lsu_rvalid_o)
      begin
        exp_word = lsu_exp_q.pop_front();
        if (lsu_chk_q.pop_front())
          check_word("lsu_rdata_o", lsu_rdata_o, exp_word);
      end
      if (mem_ack_o && mem_exp_q.size() == 0)
      begin
        log_failure("mem_ack_o with no slave-port request outstanding");
      end
      else if (mem_ack_o)
      begin
        exp_word = mem_exp_q.pop_front();
        if (mem_chk_q.pop_front())
          check_word("mem_dat_o", mem_dat_o, exp_word);
      end
      local_gnt_prev = lsu_gnt_o && is_local_addr(lsu_addr_i);
      ext_ack_prev   = ext_cyc_o && ext_ack_i;
    end
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt <= MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    errors         = 0;
    checks         = 0;
    lsu_rng        = SEED;
    mem_rng        = xorshift(SEED);
    local_gnt_prev = 1'b0;
    ext_ack_prev   = 1'b0;
    rst_n          = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_addr_i     = '0;
    lsu_we_i       = 1'b0;
    lsu_be_i       = '0;
    lsu_wdata_i    = '0;
    ext_dat_i      = '0;
    ext_ack_i      = 1'b0;
    mem_cyc_i      = 1'b0;
    mem_stb_i      = 1'b0;
    mem_we_i       = 1'b0;
    mem_adr_i      = '0;
    mem_sel_i      = '0;
    mem_dat_i      = '0;
    for (int i = 0; i < core_region_pkg::RAM_DEPTH; i++)
    begin
      ext_mem[i]    = {6'h2d, i[9:0], 6'h15, i[9:0]};
      ext_shadow[i] = ext_mem[i];
    end

    repeat (10)
      @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    checks++;
    if (lsu_gnt_o !== 1'b0 || lsu_rvalid_o !== 1'b0 || ext_cyc_o !== 1'b0 ||
        ext_stb_o !== 1'b0 || mem_ack_o !== 1'b0)
    begin
      errors++;
      $display("[ERROR] %0t outputs after reset: gnt %b rvalid %b cyc %b stb %b ack %b",
               $time, lsu_gnt_o, lsu_rvalid_o, ext_cyc_o, ext_stb_o, mem_ack_o);
    end
    @(posedge clk);
    #1;

    // local ram full words and partial writes then read back
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      lsu_rng = xorshift(lsu_rng);
      lsu_op(make_addr(1'b0, i, lsu_rng), 1'b1, 4'hf, lsu_rng ^ 32'h3c3c_0f0f);
    end
    repeat (NUM_WORDS)
      random_lsu_op(2'd0, 1'b1);
    for (int i = 0; i < NUM_WORDS; i++)
      lsu_read(i);

    repeat (12)
      random_lsu_op(2'd1, 1'b0);

    // slave port to lsu and back
    for (int i = 0; i < 8; i++)
    begin
      mem_rng = xorshift(mem_rng);
      mem_op(i, 1'b1, 4'hf, mem_rng);
    end
    for (int i = 0; i < 8; i++)
      lsu_read(i);
    for (int i = 8; i < NUM_WORDS; i++)
    begin
      lsu_rng = xorshift(lsu_rng);
      lsu_op(make_addr(1'b0, i, lsu_rng), 1'b1, 4'hf, ~lsu_rng);
    end
    for (int i = 8; i < NUM_WORDS; i++)
      mem_op(i, 1'b0, 4'hf, '0);

    // both ports fight over the ram
    fork
      repeat (40)
        random_lsu_op(2'd0, 1'b0);
      repeat (40)
        random_mem_op();
    join
    for (int i = 0; i < NUM_WORDS; i++)
      lsu_read(i);

    repeat (40)
      random_lsu_op(2'd2, 1'b0);

    while (lsu_exp_q.size() != 0 || mem_exp_q.size() != 0)
      @(posedge clk);
    repeat (4)
      @(posedge clk);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* design/core_region.sv */
`timescale 1ns/10ps

module core_region
(
  input  logic                         clk,
  input  logic                         rst_n,

  // load/store port from the core
  input  logic                         lsu_req_i,
  input  core_region_pkg::bus_addr_t   lsu_addr_i,
  input  logic                         lsu_we_i,
  input  core_region_pkg::byte_en_t    lsu_be_i,
  input  core_region_pkg::word_t       lsu_wdata_i,
  output logic                         lsu_gnt_o,
  output logic                         lsu_rvalid_o,
  output core_region_pkg::word_t       lsu_rdata_o,

  // wishbone master to the outside
  output logic                         ext_cyc_o,
  output logic                         ext_stb_o,
  output logic                         ext_we_o,
  output core_region_pkg::bus_addr_t   ext_adr_o,
  output core_region_pkg::byte_en_t    ext_sel_o,
  output core_region_pkg::word_t       ext_dat_o,
  input  core_region_pkg::word_t       ext_dat_i,
  input  logic                         ext_ack_i,

  // wishbone slave into the data ram
  input  logic                         mem_cyc_i,
  input  logic                         mem_stb_i,
  input  logic                         mem_we_i,
  input  core_region_pkg::ram_addr_t   mem_adr_i,
  input  core_region_pkg::byte_en_t    mem_sel_i,
  input  core_region_pkg::word_t       mem_dat_i,
  output core_region_pkg::word_t       mem_dat_o,
  output logic                         mem_ack_o
);

  logic                       dmx_ram_req;
  logic                       dmx_ram_gnt;
  logic                       dmx_ram_rvalid;
  core_region_pkg::word_t     dmx_ram_rdata;

  logic                       dmx_ext_req;
  logic                       dmx_ext_gnt;
  logic                       dmx_ext_rvalid;
  core_region_pkg::word_t     dmx_ext_rdata;

  logic                       slv_req;
  logic                       slv_we;
  core_region_pkg::ram_addr_t slv_addr;
  core_region_pkg::byte_en_t  slv_be;
  core_region_pkg::word_t     slv_wdata;
  core_region_pkg::word_t     slv_rdata;

  logic                       sram_en;
  logic                       sram_we;
  core_region_pkg::ram_addr_t sram_addr;
  core_region_pkg::byte_en_t  sram_be;
  core_region_pkg::word_t     sram_wdata;
  core_region_pkg::word_t     sram_rdata;

  lsu_demux lsu_demux_inst
  (
    .clk          ( clk            ),
    .rst_n        ( rst_n          ),
    .lsu_req_i    ( lsu_req_i      ),
    .lsu_addr_i   ( lsu_addr_i     ),
    .lsu_we_i     ( lsu_we_i       ),
    .lsu_be_i     ( lsu_be_i       ),
    .lsu_wdata_i  ( lsu_wdata_i    ),
    .lsu_gnt_o    ( lsu_gnt_o      ),
    .lsu_rvalid_o ( lsu_rvalid_o   ),
    .lsu_rdata_o  ( lsu_rdata_o    ),
    .ram_req_o    ( dmx_ram_req    ),
    .ext_req_o    ( dmx_ext_req    ),
    .ram_gnt_i    ( dmx_ram_gnt    ),
    .ram_rvalid_i ( dmx_ram_rvalid ),
    .ext_gnt_i    ( dmx_ext_gnt    ),
    .ext_rvalid_i ( dmx_ext_rvalid ),
    .ram_rdata_i  ( dmx_ram_rdata  ),
    .ext_rdata_i  ( dmx_ext_rdata  )
  );

  wb_master_bridge wb_master_bridge_inst
  (
    .clk       ( clk            ),
    .rst_n     ( rst_n          ),
    .req_i     ( dmx_ext_req    ),
    .we_i      ( lsu_we_i       ),
    .addr_i    ( lsu_addr_i     ),
    .be_i      ( lsu_be_i       ),
    .wdata_i   ( lsu_wdata_i    ),
    .gnt_o     ( dmx_ext_gnt    ),
    .rvalid_o  ( dmx_ext_rvalid ),
    .rdata_o   ( dmx_ext_rdata  ),
    .ext_cyc_o ( ext_cyc_o      ),
    .ext_stb_o ( ext_stb_o      ),
    .ext_we_o  ( ext_we_o       ),
    .ext_adr_o ( ext_adr_o      ),
    .ext_sel_o ( ext_sel_o      ),
    .ext_dat_o ( ext_dat_o      ),
    .ext_dat_i ( ext_dat_i      ),
    .ext_ack_i ( ext_ack_i      )
  );

  wb_slave_bridge wb_slave_bridge_inst
  (
    .clk         ( clk       ),
    .rst_n       ( rst_n     ),
    .mem_cyc_i   ( mem_cyc_i ),
    .mem_stb_i   ( mem_stb_i ),
    .mem_we_i    ( mem_we_i  ),
    .mem_adr_i   ( mem_adr_i ),
    .mem_sel_i   ( mem_sel_i ),
    .mem_dat_i   ( mem_dat_i ),
    .mem_dat_o   ( mem_dat_o ),
    .mem_ack_o   ( mem_ack_o ),
    .bus_req_o   ( slv_req   ),
    .bus_we_o    ( slv_we    ),
    .bus_addr_o  ( slv_addr  ),
    .bus_be_o    ( slv_be    ),
    .bus_wdata_o ( slv_wdata ),
    .bus_rdata_i ( slv_rdata )
  );

  ram_arbiter ram_arbiter_inst
  (
    .clk           ( clk            ),
    .rst_n         ( rst_n          ),
    .bus_req_i     ( slv_req        ),
    .bus_we_i      ( slv_we         ),
    .bus_addr_i    ( slv_addr       ),
    .bus_be_i      ( slv_be         ),
    .bus_wdata_i   ( slv_wdata      ),
    .bus_rdata_o   ( slv_rdata      ),
    .core_req_i    ( dmx_ram_req    ),
    .core_we_i     ( lsu_we_i       ),
    .core_addr_i   ( lsu_addr_i     ),
    .core_be_i     ( lsu_be_i       ),
    .core_wdata_i  ( lsu_wdata_i    ),
    .core_gnt_o    ( dmx_ram_gnt    ),
    .core_rvalid_o ( dmx_ram_rvalid ),
    .core_rdata_o  ( dmx_ram_rdata  ),
    .ram_en_o      ( sram_en        ),
    .ram_we_o      ( sram_we        ),
    .ram_addr_o    ( sram_addr      ),
    .ram_be_o      ( sram_be        ),
    .ram_wdata_o   ( sram_wdata     ),
    .ram_rdata_i   ( sram_rdata     )
  );

  data_ram data_ram_inst
  (
    .clk     ( clk        ),
    .en_i    ( sram_en    ),
    .we_i    ( sram_we    ),
    .addr_i  ( sram_addr  ),
    .be_i    ( sram_be    ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

endmodule

/* design/data_ram.sv */
`timescale 1ns/10ps

module data_ram
(
  input  logic                         clk,

  input  logic                         en_i,
  input  logic                         we_i,
  input  core_region_pkg::ram_addr_t   addr_i,
  input  core_region_pkg::byte_en_t    be_i,
  input  core_region_pkg::word_t       wdata_i,
  output core_region_pkg::word_t       rdata_o
);

  core_region_pkg::word_t mem [core_region_pkg::RAM_DEPTH];

  // read returns the old word on a write
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        for (int i = 0; i < core_region_pkg::BE_WIDTH; i++)
        begin
          if (be_i[i])
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

/* design/ram_arbiter.sv */
`timescale 1ns/10ps

module ram_arbiter
(
  input  logic                         clk,
  input  logic                         rst_n,

  // bus port always wins
  input  logic                         bus_req_i,
  input  logic                         bus_we_i,
  input  core_region_pkg::ram_addr_t   bus_addr_i,
  input  core_region_pkg::byte_en_t    bus_be_i,
  input  core_region_pkg::word_t       bus_wdata_i,
  output core_region_pkg::word_t       bus_rdata_o,

  // core port
  input  logic                         core_req_i,
  input  logic                         core_we_i,
  input  core_region_pkg::bus_addr_t   core_addr_i,
  input  core_region_pkg::byte_en_t    core_be_i,
  input  core_region_pkg::word_t       core_wdata_i,
  output logic                         core_gnt_o,
  output logic                         core_rvalid_o,
  output core_region_pkg::word_t       core_rdata_o,

  output logic                         ram_en_o,
  output logic                         ram_we_o,
  output core_region_pkg::ram_addr_t   ram_addr_o,
  output core_region_pkg::byte_en_t    ram_be_o,
  output core_region_pkg::word_t       ram_wdata_o,
  input  core_region_pkg::word_t       ram_rdata_i
);

  core_region_pkg::ram_addr_t core_word_addr;
  logic                       core_owner_q;

  // byte address to word address
  assign core_word_addr = core_addr_i[core_region_pkg::RAM_ADDR_WIDTH+1:2];

  assign core_gnt_o = core_req_i & ~bus_req_i;
  assign ram_en_o   = bus_req_i | core_req_i;

  always_comb
  begin
    if (bus_req_i)
    begin
      ram_we_o    = bus_we_i;
      ram_addr_o  = bus_addr_i;
      ram_be_o    = bus_be_i;
      ram_wdata_o = bus_wdata_i;
    end
    else
    begin
      ram_we_o    = core_we_i;
      ram_addr_o  = core_word_addr;
      ram_be_o    = core_be_i;
      ram_wdata_o = core_wdata_i;
    end
  end

  // who owned the ram last cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      core_owner_q <= 1'b0;
    else
      core_owner_q <= core_gnt_o;
  end

  assign core_rvalid_o = core_owner_q;

  // both sides share the one read port
  assign bus_rdata_o  = ram_rdata_i;
  assign core_rdata_o = ram_rdata_i;

  a_bus_priority: assert property (@(posedge clk) disable iff (!rst_n)
    !(core_gnt_o && bus_req_i));

endmodule

/* design/wb_slave_bridge.sv */
`timescale 1ns/10ps

module wb_slave_bridge
(
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         mem_cyc_i,
  input  logic                         mem_stb_i,
  input  logic                         mem_we_i,
  input  core_region_pkg::ram_addr_t   mem_adr_i,
  input  core_region_pkg::byte_en_t    mem_sel_i,
  input  core_region_pkg::word_t       mem_dat_i,
  output core_region_pkg::word_t       mem_dat_o,
  output logic                         mem_ack_o,

  output logic                         bus_req_o,
  output logic                         bus_we_o,
  output core_region_pkg::ram_addr_t   bus_addr_o,
  output core_region_pkg::byte_en_t    bus_be_o,
  output core_region_pkg::word_t       bus_wdata_o,
  input  core_region_pkg::word_t       bus_rdata_i
);

  logic ack_q;

  // no second request while stb is still up in the ack cycle
  assign bus_req_o   = mem_cyc_i & mem_stb_i & ~ack_q;
  assign bus_we_o    = mem_we_i;
  assign bus_addr_o  = mem_adr_i;
  assign bus_be_o    = mem_sel_i;
  assign bus_wdata_o = mem_dat_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      ack_q <= 1'b0;
    else
      ack_q <= bus_req_o;
  end

  assign mem_ack_o = ack_q;

  // ram read data lands together with ack
  assign mem_dat_o = bus_rdata_i;

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ack_o |=> !mem_ack_o);

endmodule

/* design/wb_master_bridge.sv */
`timescale 1ns/10ps

module wb_master_bridge
(
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         req_i,
  input  logic                         we_i,
  input  core_region_pkg::bus_addr_t   addr_i,
  input  core_region_pkg::byte_en_t    be_i,
  input  core_region_pkg::word_t       wdata_i,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output core_region_pkg::word_t       rdata_o,

  output logic                         ext_cyc_o,
  output logic                         ext_stb_o,
  output logic                         ext_we_o,
  output core_region_pkg::bus_addr_t   ext_adr_o,
  output core_region_pkg::byte_en_t    ext_sel_o,
  output core_region_pkg::word_t       ext_dat_o,
  input  core_region_pkg::word_t       ext_dat_i,
  input  logic                         ext_ack_i
);

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e state_q;
  state_e state_d;

  assign gnt_o     = (state_q == ST_IDLE) & req_i;
  assign ext_cyc_o = (state_q == ST_WAIT);
  assign ext_stb_o = (state_q == ST_WAIT);
  assign rvalid_o  = (state_q == ST_RESP);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
      begin
        if (req_i)
          state_d = ST_WAIT;
      end
      ST_WAIT:
      begin
        if (ext_ack_i)
          state_d = ST_RESP;
      end
      ST_RESP:
      begin
        state_d = ST_IDLE;
      end
      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // request fields and returned data
  always_ff @(posedge clk)
  begin
    if (gnt_o)
    begin
      ext_we_o  <= we_i;
      ext_adr_o <= addr_i;
      ext_sel_o <= be_i;
      ext_dat_o <= wdata_i;
    end
    if (ext_cyc_o && ext_ack_i)
      rdata_o <= ext_dat_i;
  end

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    ext_stb_o |-> ext_cyc_o);

endmodule

/* design/lsu_demux.sv */
`timescale 1ns/10ps

module lsu_demux
(
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         lsu_req_i,
  input  core_region_pkg::bus_addr_t   lsu_addr_i,
  input  logic                         lsu_we_i,
  input  core_region_pkg::byte_en_t    lsu_be_i,
  input  core_region_pkg::word_t       lsu_wdata_i,
  output logic                         lsu_gnt_o,
  output logic                         lsu_rvalid_o,
  output core_region_pkg::word_t       lsu_rdata_o,

  output logic                         ram_req_o,
  output logic                         ext_req_o,
  input  logic                         ram_gnt_i,
  input  logic                         ram_rvalid_i,
  input  logic                         ext_gnt_i,
  input  logic                         ext_rvalid_i,
  input  core_region_pkg::word_t       ram_rdata_i,
  input  core_region_pkg::word_t       ext_rdata_i
);

  logic                       is_local;
  logic                       pending;
  logic                       block_ram;
  logic                       block_ext;
  logic [1:0]                 pend_cnt;
  core_region_pkg::resp_src_e resp_src;

  // payload goes straight to both targets, only req is steered
  assign is_local = (lsu_addr_i[core_region_pkg::ADDR_WIDTH-1 -: core_region_pkg::REGION_WIDTH]
                     == core_region_pkg::LOCAL_REGION);

  // keep responses in order across targets
  assign pending   = (pend_cnt != 2'd0);
  assign block_ram = pending && (resp_src == core_region_pkg::SRC_EXT);
  assign block_ext = pending && (resp_src == core_region_pkg::SRC_RAM);

  assign ram_req_o = lsu_req_i &  is_local & ~block_ram;
  assign ext_req_o = lsu_req_i & ~is_local & ~block_ext;

  assign lsu_gnt_o = is_local ? (ram_gnt_i & ~block_ram) : (ext_gnt_i & ~block_ext);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_cnt <= 2'd0;
      resp_src <= core_region_pkg::SRC_RAM;
    end
    else
    begin
      if (lsu_gnt_o && !lsu_rvalid_o)
        pend_cnt <= pend_cnt + 2'd1;
      else if (!lsu_gnt_o && lsu_rvalid_o)
        pend_cnt <= pend_cnt - 2'd1;

      if (lsu_gnt_o)
        resp_src <= is_local ? core_region_pkg::SRC_RAM : core_region_pkg::SRC_EXT;
    end
  end

  // route response back from the pending source
  always_comb
  begin
    if (resp_src == core_region_pkg::SRC_EXT)
    begin
      lsu_rvalid_o = ext_rvalid_i;
      lsu_rdata_o  = ext_rdata_i;
    end
    else
    begin
      lsu_rvalid_o = ram_rvalid_i;
      lsu_rdata_o  = ram_rdata_i;
    end
  end

  // targets only grant what was requested
  a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_gnt_o |-> lsu_req_i);

  // lsu_we_i, lsu_be_i and lsu_wdata_i are wired to the targets at the top
  a_payload_known: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_gnt_o |-> !$isunknown({lsu_we_i, lsu_be_i, lsu_wdata_i}));

endmodule

/* design/core_region_pkg.sv */
package core_region_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int BE_WIDTH       = 4;
  localparam int ADDR_WIDTH     = 32;
  localparam int RAM_ADDR_WIDTH = 10;
  localparam int RAM_DEPTH      = 1024;

  // top of the byte address selects the target
  localparam int REGION_WIDTH                   = 12;
  localparam logic [REGION_WIDTH-1:0] LOCAL_REGION = 12'h001;

  typedef logic [DATA_WIDTH-1:0]     word_t;
  typedef logic [BE_WIDTH-1:0]       byte_en_t;
  typedef logic [ADDR_WIDTH-1:0]     bus_addr_t;
  typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

  // where the next lsu response comes from
  typedef enum logic [0:0]
  {
    SRC_RAM = 1'b0,
    SRC_EXT = 1'b1
  } resp_src_e;

endpackage
